//--- Bender.yml
package:
  name: fetch_unit

dependencies: {}

sources:
  - files:
      - hdl/fetch_pkg.sv
      - hdl/fetch_buffer.sv
      - hdl/instr_predecode.sv
      - hdl/branch_predictor.sv
      - hdl/fetch_stage.sv
      - hdl/fetch_unit.sv
  - target: test
    include_dirs:
      - include
    files:
      - verif/fetch_unit_tb.sv

//--- filelist.f
+incdir+include
hdl/fetch_pkg.sv
hdl/fetch_buffer.sv
hdl/instr_predecode.sv
hdl/branch_predictor.sv
hdl/fetch_stage.sv
hdl/fetch_unit.sv
verif/fetch_unit_tb.sv

//--- hdl/branch_predictor.sv
`timescale 1ns/1ps

module branch_predictor #(
  parameter int ADDR_WIDTH = 16,
  parameter int BHT_BITS = 6,
  parameter int RAS_DEPTH = 4
) (
  input  logic                  clock,
  input  logic                  reset,
  input  logic [ADDR_WIDTH-1:0] pc,
  input  fetch_pkg::ctrl_kind_t kind,
  input  logic [ADDR_WIDTH-1:0] link,
  input  logic                  advance,
  input  logic                  resolve_valid,
  input  logic [ADDR_WIDTH-1:0] resolve_pc,
  input  logic                  resolve_taken,
  output logic                  pred_taken,
  output logic                  ras_valid,
  output logic [ADDR_WIDTH-1:0] ras_top
);
  import fetch_pkg::*;

  localparam int BHT_SIZE = 2 ** BHT_BITS;
  localparam int PTR_BITS = (RAS_DEPTH > 1) ? $clog2(RAS_DEPTH) : 1;
  localparam int CNT_BITS = $clog2(RAS_DEPTH + 1);
  localparam logic [PTR_BITS-1:0] PTR_LAST = PTR_BITS'(RAS_DEPTH - 1);
  localparam logic [CNT_BITS-1:0] CNT_FULL = CNT_BITS'(RAS_DEPTH);

  logic [1:0]            bht [BHT_SIZE];
  logic [BHT_BITS-1:0]   lookup_idx;
  logic [BHT_BITS-1:0]   update_idx;
  logic [1:0]            update_ctr;
  logic [ADDR_WIDTH-1:0] ras [RAS_DEPTH];
  logic [PTR_BITS-1:0]   ras_ptr;
  logic [PTR_BITS-1:0]   ptr_inc;
  logic [PTR_BITS-1:0]   ptr_dec;
  logic [CNT_BITS-1:0]   ras_count;
  logic                  push;
  logic                  pop;

  // pc bit 0 is always zero so the index starts at bit 1
  assign lookup_idx = pc[BHT_BITS:1];
  assign update_idx = resolve_pc[BHT_BITS:1];
  assign pred_taken = (kind == kind_branch) && bht[lookup_idx][1];

  always_comb begin
    update_ctr = bht[update_idx];
    if (resolve_taken && update_ctr != 2'b11) begin
      update_ctr = update_ctr + 2'b01;
    end else if (!resolve_taken && update_ctr != 2'b00) begin
      update_ctr = update_ctr - 2'b01;
    end
  end

  always_ff @(posedge clock) begin
    if (!reset) begin
      for (int i = 0; i < BHT_SIZE; i++) begin
        bht[i] <= 2'b01;
      end
    end else if (resolve_valid) begin
      bht[update_idx] <= update_ctr;
    end
  end

  // ras_ptr points at the next free slot, the top sits just below it
  assign push = advance && (kind == kind_call);
  assign pop = advance && (kind == kind_return) && ras_valid;
  assign ptr_inc = (ras_ptr == PTR_LAST) ? '0 : ras_ptr + 1'b1;
  assign ptr_dec = (ras_ptr == '0) ? PTR_LAST : ras_ptr - 1'b1;
  assign ras_valid = (ras_count != '0);
  assign ras_top = ras[ptr_dec];

  always_ff @(posedge clock) begin
    if (!reset) begin
      ras_ptr <= '0;
      ras_count <= '0;
    end else if (push) begin
      ras_ptr <= ptr_inc;
      if (ras_count != CNT_FULL) begin
        ras_count <= ras_count + 1'b1;
      end
    end else if (pop) begin
      ras_ptr <= ptr_dec;
      ras_count <= ras_count - 1'b1;
    end
  end

  // when full the push lands on the oldest entry
  always_ff @(posedge clock) begin
    if (push) begin
      ras[ras_ptr] <= link;
    end
  end

  assert property (@(posedge clock) disable iff (!reset) ras_count <= CNT_FULL)
    else $error("return stack count above depth");

endmodule

//--- hdl/fetch_buffer.sv
`timescale 1ns/1ps

module fetch_buffer #(
  parameter int ADDR_WIDTH = 16,
  parameter int MEM_HALFWORDS = 1024
) (
  input  logic                             clock,
  input  logic                             load_valid,
  input  logic [$clog2(MEM_HALFWORDS)-1:0] load_addr,
  input  logic [15:0]                      load_data,
  input  logic [ADDR_WIDTH-1:0]            pc,
  output fetch_pkg::instr_word_t           word
);

  localparam int IDX_BITS = $clog2(MEM_HALFWORDS);

  logic [15:0]         mem [MEM_HALFWORDS];
  logic [IDX_BITS-1:0] lo_idx;
  logic [IDX_BITS-1:0] hi_idx;

  always_ff @(posedge clock) begin
    if (load_valid) begin
      mem[load_addr] <= load_data;
    end
  end

  // the halfword index wraps so the last entry pairs with the first
  assign lo_idx = IDX_BITS'(32'(pc[ADDR_WIDTH-1:1]) % MEM_HALFWORDS);
  assign hi_idx = (lo_idx == IDX_BITS'(MEM_HALFWORDS - 1)) ? '0 : lo_idx + 1'b1;

  // two independent halfwords let a 32-bit instruction straddle a word boundary
  always_comb begin
    word.c.lo = mem[lo_idx];
    word.c.hi = mem[hi_idx];
  end

  assert property (@(posedge clock) !$isunknown(pc) |-> pc[0] == 1'b0)
    else $error("fetch pc %h is not halfword aligned", pc);

endmodule

//--- hdl/fetch_pkg.sv
package fetch_pkg;

  // full-width instruction seen in I-type layout, other formats pick raw bits
  typedef struct packed {
    logic [11:0] imm;
    logic [4:0]  rs1;
    logic [2:0]  funct3;
    logic [4:0]  rd;
    logic [6:0]  opcode;
  } instr32_t;

  // one compressed halfword in CR/CB style layout
  typedef struct packed {
    logic [2:0] funct3;
    logic       bit12;
    logic [4:0] rs1;
    logic [4:0] rs2;
    logic [1:0] op;
  } chalf_t;

  typedef struct packed {
    chalf_t hi;
    chalf_t lo;
  } cpair_t;

  typedef union packed {
    instr32_t i;
    cpair_t   c;
  } instr_word_t;

  typedef enum logic [2:0] {
    kind_none,
    kind_branch,
    kind_jump,
    kind_call,
    kind_return,
    kind_indirect
  } ctrl_kind_t;

  localparam logic [6:0] opcode_branch = 7'b1100011;
  localparam logic [6:0] opcode_jal    = 7'b1101111;
  localparam logic [6:0] opcode_jalr   = 7'b1100111;
  localparam logic [2:0] funct3_jalr   = 3'b000;

  localparam logic [1:0] quad_c1   = 2'b01;
  localparam logic [1:0] quad_c2   = 2'b10;
  localparam logic [1:0] quad_full = 2'b11;

  localparam logic [2:0] c_funct3_jal  = 3'b001;
  localparam logic [2:0] c_funct3_j    = 3'b101;
  localparam logic [2:0] c_funct3_beqz = 3'b110;
  localparam logic [2:0] c_funct3_bnez = 3'b111;
  localparam logic [2:0] c_funct3_jr   = 3'b100;

  localparam logic [4:0] reg_zero = 5'd0;
  localparam logic [4:0] reg_ra   = 5'd1;

  // addi x0, x0, 0
  localparam logic [31:0] nop_instr = 32'h0000_0013;

endpackage

//--- hdl/fetch_stage.sv
`timescale 1ns/1ps

module fetch_stage #(
  parameter int ADDR_WIDTH = 16,
  parameter logic [ADDR_WIDTH-1:0] TRAP_VECTOR = ADDR_WIDTH'('h0100)
) (
  input  logic                   clock,
  input  logic                   reset,
  input  logic                   stall,
  input  logic                   trap,
  input  logic                   mret,
  input  logic [ADDR_WIDTH-1:0]  epc,
  input  logic                   redirect,
  input  logic [ADDR_WIDTH-1:0]  redirect_pc,
  input  fetch_pkg::instr_word_t word,
  input  fetch_pkg::ctrl_kind_t  kind,
  input  logic                   len4,
  input  logic [ADDR_WIDTH-1:0]  target,
  input  logic                   pred_taken,
  input  logic                   ras_valid,
  input  logic [ADDR_WIDTH-1:0]  ras_top,
  output logic [ADDR_WIDTH-1:0]  pc,
  output logic                   advance,
  output logic                   fetch_valid,
  output logic [ADDR_WIDTH-1:0]  fetch_pc,
  output logic [31:0]            fetch_instr,
  output logic                   fetch_len4,
  output logic                   fetch_taken
);
  import fetch_pkg::*;

  logic [ADDR_WIDTH-1:0] next_pc;
  logic                  next_taken;
  logic                  redirect_any;
  logic                  jalr_form;

  assign redirect_any = trap || mret || redirect;
  assign advance = !stall && !redirect_any;

  // calls through jalr or c.jalr have no static target and fall through
  assign jalr_form = len4 ? (word.i.opcode == opcode_jalr) : (word.c.lo.op == quad_c2);

  always_comb begin
    next_taken = 1'b0;
    if (trap) begin
      next_pc = TRAP_VECTOR;
    end else if (mret) begin
      next_pc = epc;
    end else if (redirect) begin
      next_pc = redirect_pc;
    end else if (kind == kind_return && ras_valid) begin
      next_pc = ras_top;
      next_taken = 1'b1;
    end else if (kind == kind_jump || (kind == kind_call && !jalr_form)) begin
      next_pc = target;
      next_taken = 1'b1;
    end else if (kind == kind_branch && pred_taken) begin
      next_pc = target;
      next_taken = 1'b1;
    end else begin
      next_pc = pc + (len4 ? ADDR_WIDTH'(4) : ADDR_WIDTH'(2));
    end
  end

  // redirects act even under stall and drop the result in flight
  always_ff @(posedge clock) begin
    if (!reset) begin
      pc <= TRAP_VECTOR;
      fetch_valid <= 1'b0;
      fetch_pc <= '0;
      fetch_instr <= nop_instr;
      fetch_len4 <= 1'b0;
      fetch_taken <= 1'b0;
    end else if (redirect_any) begin
      pc <= next_pc;
      fetch_valid <= 1'b0;
      fetch_instr <= nop_instr;
      fetch_taken <= 1'b0;
    end else if (!stall) begin
      pc <= next_pc;
      fetch_valid <= 1'b1;
      fetch_pc <= pc;
      fetch_instr <= word;
      fetch_len4 <= len4;
      fetch_taken <= next_taken;
    end
  end

  assert property (@(posedge clock) disable iff (!reset) !(trap && mret))
    else $error("trap and mret raised in the same cycle");

  assert property (@(posedge clock) disable iff (!reset) fetch_taken |-> fetch_valid)
    else $error("taken result without a valid fetch");

endmodule

//--- hdl/fetch_unit.sv
`timescale 1ns/1ps

module fetch_unit #(
  parameter int ADDR_WIDTH = 16,
  parameter int MEM_HALFWORDS = 1024,
  parameter int BHT_BITS = 6,
  parameter int RAS_DEPTH = 4,
  parameter logic [ADDR_WIDTH-1:0] TRAP_VECTOR = ADDR_WIDTH'('h0100)
) (
  input  logic                             clock,
  input  logic                             reset,
  input  logic                             load_valid,
  input  logic [$clog2(MEM_HALFWORDS)-1:0] load_addr,
  input  logic [15:0]                      load_data,
  input  logic                             stall,
  input  logic                             trap,
  input  logic                             mret,
  input  logic [ADDR_WIDTH-1:0]            epc,
  input  logic                             redirect,
  input  logic [ADDR_WIDTH-1:0]            redirect_pc,
  input  logic                             resolve_valid,
  input  logic [ADDR_WIDTH-1:0]            resolve_pc,
  input  logic                             resolve_taken,
  output logic                             fetch_valid,
  output logic [ADDR_WIDTH-1:0]            fetch_pc,
  output logic [31:0]                      fetch_instr,
  output logic                             fetch_len4,
  output logic                             fetch_taken
);
  import fetch_pkg::*;

  logic [ADDR_WIDTH-1:0] pc;
  instr_word_t           word;
  ctrl_kind_t            kind;
  logic                  len4;
  logic [ADDR_WIDTH-1:0] target;
  logic [ADDR_WIDTH-1:0] link;
  logic                  pred_taken;
  logic                  ras_valid;
  logic [ADDR_WIDTH-1:0] ras_top;
  logic                  advance;

  fetch_buffer #(.ADDR_WIDTH(ADDR_WIDTH), .MEM_HALFWORDS(MEM_HALFWORDS)) fetch_buffer_inst (
    .clock(clock), .load_valid(load_valid), .load_addr(load_addr),
    .load_data(load_data), .pc(pc), .word(word)
  );

  instr_predecode #(.ADDR_WIDTH(ADDR_WIDTH)) instr_predecode_inst (
    .word(word), .pc(pc), .kind(kind), .len4(len4), .target(target), .link(link)
  );

  // counters hold under stall, so resolve updates are dropped then
  branch_predictor #(
    .ADDR_WIDTH(ADDR_WIDTH), .BHT_BITS(BHT_BITS), .RAS_DEPTH(RAS_DEPTH)
  ) branch_predictor_inst (
    .clock(clock), .reset(reset), .pc(pc), .kind(kind), .link(link), .advance(advance),
    .resolve_valid(resolve_valid && !stall), .resolve_pc(resolve_pc),
    .resolve_taken(resolve_taken), .pred_taken(pred_taken), .ras_valid(ras_valid),
    .ras_top(ras_top)
  );

  fetch_stage #(.ADDR_WIDTH(ADDR_WIDTH), .TRAP_VECTOR(TRAP_VECTOR)) fetch_stage_inst (
    .clock(clock), .reset(reset), .stall(stall), .trap(trap), .mret(mret), .epc(epc),
    .redirect(redirect), .redirect_pc(redirect_pc), .word(word), .kind(kind),
    .len4(len4), .target(target), .pred_taken(pred_taken), .ras_valid(ras_valid),
    .ras_top(ras_top), .pc(pc), .advance(advance), .fetch_valid(fetch_valid),
    .fetch_pc(fetch_pc), .fetch_instr(fetch_instr), .fetch_len4(fetch_len4),
    .fetch_taken(fetch_taken)
  );

endmodule

//--- hdl/instr_predecode.sv
`timescale 1ns/1ps

module instr_predecode #(
  parameter int ADDR_WIDTH = 16
) (
  input  fetch_pkg::instr_word_t word,
  input  logic [ADDR_WIDTH-1:0]  pc,
  output fetch_pkg::ctrl_kind_t  kind,
  output logic                   len4,
  output logic [ADDR_WIDTH-1:0]  target,
  output logic [ADDR_WIDTH-1:0]  link
);
  import fetch_pkg::*;

  logic [31:0] raw;
  logic [15:0] half;
  logic [31:0] offset;

  assign raw = word;
  assign half = word.c.lo;

  // the low two bits decide which view of the word applies
  assign len4 = (word.c.lo.op == quad_full);

  always_comb begin
    kind = kind_none;
    offset = '0;
    if (len4) begin
      case (word.i.opcode)
        opcode_branch: begin
          // funct3 010 and 011 are not branches
          if (word.i.funct3[2:1] != 2'b01) begin
            kind = kind_branch;
            offset = {{20{raw[31]}}, raw[7], raw[30:25], raw[11:8], 1'b0};
          end
        end
        opcode_jal: begin
          kind = (word.i.rd == reg_ra) ? kind_call : kind_jump;
          offset = {{12{raw[31]}}, raw[19:12], raw[20], raw[30:21], 1'b0};
        end
        opcode_jalr: begin
          if (word.i.funct3 == funct3_jalr) begin
            if (word.i.rd == reg_ra) begin
              kind = kind_call;
            end else if (word.i.rd == reg_zero && word.i.rs1 == reg_ra &&
                         word.i.imm == '0) begin
              kind = kind_return;
            end else begin
              kind = kind_indirect;
            end
          end
        end
        default: begin
          kind = kind_none;
        end
      endcase
    end else begin
      case (word.c.lo.op)
        quad_c1: begin
          case (word.c.lo.funct3)
            c_funct3_jal, c_funct3_j: begin
              kind = (word.c.lo.funct3 == c_funct3_jal) ? kind_call : kind_jump;
              offset = {{21{half[12]}}, half[8], half[10:9], half[6], half[7], half[2],
                        half[11], half[5:3], 1'b0};
            end
            c_funct3_beqz, c_funct3_bnez: begin
              kind = kind_branch;
              offset = {{24{half[12]}}, half[6:5], half[2], half[11:10], half[4:3], 1'b0};
            end
            default: begin
              kind = kind_none;
            end
          endcase
        end
        quad_c2: begin
          // c.jr and c.jalr have rs2 zero and a nonzero rs1
          if (word.c.lo.funct3 == c_funct3_jr && word.c.lo.rs2 == reg_zero &&
              word.c.lo.rs1 != reg_zero) begin
            if (word.c.lo.bit12) begin
              kind = kind_call;
            end else if (word.c.lo.rs1 == reg_ra) begin
              kind = kind_return;
            end else begin
              kind = kind_indirect;
            end
          end
        end
        default: begin
          kind = kind_none;
        end
      endcase
    end
  end

  assign target = pc + offset[ADDR_WIDTH-1:0];
  assign link = pc + (len4 ? ADDR_WIDTH'(4) : ADDR_WIDTH'(2));

  // any fully known word must classify to a known kind and length
  always_comb begin
    if (!$isunknown(word)) begin
      assert final (!$isunknown({kind, len4}))
        else $error("predecode output unknown for word %h", raw);
    end
  end

endmodule

//--- include/fetch_model.svh
`ifndef FETCH_MODEL_SVH
`define FETCH_MODEL_SVH

// control transfer kinds as the model sees them
localparam int ck_none = 0;
localparam int ck_branch = 1;
localparam int ck_jump = 2;
localparam int ck_call = 3;
localparam int ck_return = 4;
localparam int ck_indirect = 5;

localparam int BHT_SIZE = 1 << BHT_BITS;
// addi x0, x0, 0
localparam logic [31:0] nop_word = 32'h0000_0013;

logic [15:0]           exp_mem [MEM_HALFWORDS];
logic [1:0]            exp_bht [BHT_SIZE];
logic [ADDR_WIDTH-1:0] exp_ras [$];
logic [ADDR_WIDTH-1:0] exp_pc;
logic                  exp_valid;
logic [ADDR_WIDTH-1:0] exp_fetch_pc;
logic [31:0]           exp_instr;
logic                  exp_len4;
logic                  exp_taken;
// set when the coming edge commits a new result
logic                  new_result;

// direct is set for transfers whose target comes from the immediate
function automatic void predecode_word(input logic [31:0] w, input logic [ADDR_WIDTH-1:0] at,
                                       output int kind, output logic len4, output logic direct,
                                       output logic [ADDR_WIDTH-1:0] target,
                                       output logic [ADDR_WIDTH-1:0] link);
  logic [15:0] h;
  logic [31:0] imm;
  h = w[15:0];
  imm = '0;
  kind = ck_none;
  direct = 1'b0;
  len4 = (w[1:0] == 2'b11);
  if (len4) begin
    case (w[6:0])
      7'b1100011: begin
        if (w[14:12] != 3'b010 && w[14:12] != 3'b011) begin
          kind = ck_branch;
          imm = {{19{w[31]}}, w[31], w[7], w[30:25], w[11:8], 1'b0};
        end
      end
      7'b1101111: begin
        kind = (w[11:7] == 5'd1) ? ck_call : ck_jump;
        direct = 1'b1;
        imm = {{11{w[31]}}, w[31], w[19:12], w[20], w[30:21], 1'b0};
      end
      7'b1100111: begin
        if (w[14:12] == 3'b000) begin
          if (w[11:7] == 5'd1) begin
            kind = ck_call;
          end else if (w[11:7] == 5'd0 && w[19:15] == 5'd1 && w[31:20] == 12'd0) begin
            kind = ck_return;
          end else begin
            kind = ck_indirect;
          end
        end
      end
      default: kind = ck_none;
    endcase
  end else if (h[1:0] == 2'b01) begin
    if (h[15:13] == 3'b001 || h[15:13] == 3'b101) begin
      kind = (h[15:13] == 3'b001) ? ck_call : ck_jump;
      direct = 1'b1;
      imm = {{20{h[12]}}, h[12], h[8], h[10:9], h[6], h[7], h[2], h[11], h[5:3], 1'b0};
    end else if (h[15:14] == 2'b11) begin
      kind = ck_branch;
      imm = {{23{h[12]}}, h[12], h[6:5], h[2], h[11:10], h[4:3], 1'b0};
    end
  end else if (h[1:0] == 2'b10) begin
    if (h[15:13] == 3'b100 && h[6:2] == 5'd0 && h[11:7] != 5'd0) begin
      if (h[12]) begin
        kind = ck_call;
      end else if (h[11:7] == 5'd1) begin
        kind = ck_return;
      end else begin
        kind = ck_indirect;
      end
    end
  end
  target = at + imm[ADDR_WIDTH-1:0];
  link = at + (len4 ? ADDR_WIDTH'(4) : ADDR_WIDTH'(2));
endfunction

task automatic reset_model();
  exp_pc = TRAP_VECTOR;
  exp_valid = 1'b0;
  exp_fetch_pc = '0;
  exp_instr = nop_word;
  exp_len4 = 1'b0;
  exp_taken = 1'b0;
  new_result = 1'b0;
  for (int i = 0; i < BHT_SIZE; i++) begin
    exp_bht[i] = 2'b01;
  end
  exp_ras.delete();
endtask

// moves the model across one clock edge using the inputs driven for that edge
task automatic step_model();
  logic [31:0]           word;
  int                    kind;
  int                    lo;
  int                    hi;
  int                    ridx;
  logic                  len4;
  logic                  direct;
  logic                  pred_taken;
  logic                  ras_valid;
  logic                  redirect_any;
  logic                  commit;
  logic                  taken;
  logic [ADDR_WIDTH-1:0] target;
  logic [ADDR_WIDTH-1:0] link;
  logic [ADDR_WIDTH-1:0] next_pc;
  lo = int'((exp_pc >> 1) % MEM_HALFWORDS);
  hi = (lo + 1) % MEM_HALFWORDS;
  word = {exp_mem[hi], exp_mem[lo]};
  predecode_word(word, exp_pc, kind, len4, direct, target, link);
  pred_taken = (kind == ck_branch) && exp_bht[int'((exp_pc >> 1) % BHT_SIZE)][1];
  ras_valid = (exp_ras.size() > 0);
  redirect_any = trap || mret || redirect;
  taken = 1'b0;
  if (trap) begin
    next_pc = TRAP_VECTOR;
  end else if (mret) begin
    next_pc = epc;
  end else if (redirect) begin
    next_pc = redirect_pc;
  end else if (kind == ck_return && ras_valid) begin
    next_pc = exp_ras[$];
    taken = 1'b1;
  end else if ((kind == ck_jump || kind == ck_call) && direct) begin
    next_pc = target;
    taken = 1'b1;
  end else if (kind == ck_branch && pred_taken) begin
    next_pc = target;
    taken = 1'b1;
  end else begin
    next_pc = exp_pc + (len4 ? ADDR_WIDTH'(4) : ADDR_WIDTH'(2));
  end
  commit = !stall && !redirect_any;
  new_result = commit;
  if (resolve_valid && !stall) begin
    ridx = int'((resolve_pc >> 1) % BHT_SIZE);
    if (resolve_taken && exp_bht[ridx] != 2'b11) begin
      exp_bht[ridx] = exp_bht[ridx] + 2'b01;
    end else if (!resolve_taken && exp_bht[ridx] != 2'b00) begin
      exp_bht[ridx] = exp_bht[ridx] - 2'b01;
    end
  end
  if (commit && kind == ck_call) begin
    exp_ras.push_back(link);
    // a full stack loses its oldest entry
    if (exp_ras.size() > RAS_DEPTH) begin
      void'(exp_ras.pop_front());
    end
  end else if (commit && kind == ck_return && ras_valid) begin
    void'(exp_ras.pop_back());
  end
  if (redirect_any) begin
    exp_pc = next_pc;
    exp_valid = 1'b0;
    exp_instr = nop_word;
    exp_taken = 1'b0;
  end else if (!stall) begin
    exp_valid = 1'b1;
    exp_fetch_pc = exp_pc;
    exp_instr = word;
    exp_len4 = len4;
    exp_taken = taken;
    exp_pc = next_pc;
  end
endtask

`endif

//--- verif/fetch_unit_tb.sv
`timescale 1ns/1ps

module fetch_unit_tb;

  localparam int ADDR_WIDTH = 16;
  localparam int MEM_HALFWORDS = 1024;
  localparam int BHT_BITS = 6;
  localparam int RAS_DEPTH = 4;
  localparam logic [ADDR_WIDTH-1:0] TRAP_VECTOR = 16'h0100;
  localparam int LOAD_BITS = $clog2(MEM_HALFWORDS);
  localparam int RESET_CYCLES = 16;
  localparam int RUN_CYCLES = 4000;
  // buffer loading plus the random run plus some margin
  localparam int TIMEOUT_CYCLES = MEM_HALFWORDS + RUN_CYCLES + 1000;
  localparam logic [ADDR_WIDTH-1:0] EVEN_MASK = {{(ADDR_WIDTH-1){1'b1}}, 1'b0};

  logic                  clock;
  logic                  reset;
  logic                  load_valid;
  logic [LOAD_BITS-1:0]  load_addr;
  logic [15:0]           load_data;
  logic                  stall;
  logic                  trap;
  logic                  mret;
  logic [ADDR_WIDTH-1:0] epc;
  logic                  redirect;
  logic [ADDR_WIDTH-1:0] redirect_pc;
  logic                  resolve_valid;
  logic [ADDR_WIDTH-1:0] resolve_pc;
  logic                  resolve_taken;
  logic                  fetch_valid;
  logic [ADDR_WIDTH-1:0] fetch_pc;
  logic [31:0]           fetch_instr;
  logic                  fetch_len4;
  logic                  fetch_taken;

  logic [15:0] prog [MEM_HALFWORDS];
  int          cycle_count;
  int          results_seen;
  int          taken_seen;
  int          redirects_seen;

  `include "fetch_model.svh"

  fetch_unit #(
    .ADDR_WIDTH(ADDR_WIDTH), .MEM_HALFWORDS(MEM_HALFWORDS), .BHT_BITS(BHT_BITS),
    .RAS_DEPTH(RAS_DEPTH), .TRAP_VECTOR(TRAP_VECTOR)
  ) fetch_unit_inst (
    .clock(clock), .reset(reset), .load_valid(load_valid), .load_addr(load_addr),
    .load_data(load_data), .stall(stall), .trap(trap), .mret(mret), .epc(epc),
    .redirect(redirect), .redirect_pc(redirect_pc), .resolve_valid(resolve_valid),
    .resolve_pc(resolve_pc), .resolve_taken(resolve_taken), .fetch_valid(fetch_valid),
    .fetch_pc(fetch_pc), .fetch_instr(fetch_instr), .fetch_len4(fetch_len4),
    .fetch_taken(fetch_taken)
  );

  initial begin
    clock = 1'b0;
    forever #50 clock = ~clock;
  end

  task automatic abort_run(input string reason);
    $display("%s", reason);
    $display("sim failed");
    $fatal(1, "run stopped after a failure");
  endtask

  task automatic report_mismatch(input string name, input logic [31:0] expected,
                                 input logic [31:0] actual);
    $display("Fail %s expected %0h actual %0h", name, expected, actual);
    $display("sim failed");
    $fatal(1, "mismatch on %s", name);
  endtask

  // about a third of the stream is control transfers with small offsets
  task automatic build_program();
    int          i;
    int          pick;
    logic [31:0] bits;
    logic [31:0] instr;
    logic [12:0] boff;
    logic [20:0] joff;
    logic [2:0]  f3;
    i = 0;
    while (i < MEM_HALFWORDS) begin
      bits = $urandom;
      pick = $urandom % 20;
      boff = {{6{bits[31]}}, bits[30:25], 1'b0};
      joff = {{12{bits[31]}}, bits[30:23], 1'b0};
      f3 = {bits[14] | bits[13], bits[13:12]};
      case (pick)
        0: instr = {16'h0000, 2'b11, bits[13:2], 2'b01};
        1: instr = {16'h0000, bits[15] ? 3'b101 : 3'b001, bits[12:2], 2'b01};
        2: instr = {16'h0000, 16'h8082};
        // c.jr or c.jalr through a random register
        3: instr = {16'h0000, 3'b100, bits[12], bits[11:8], 1'b1, 5'b00000, 2'b10};
        4: begin
          instr = {boff[12], boff[10:5], bits[24:20], bits[19:15], f3, boff[4:1], boff[11],
                   7'b1100011};
        end
        5: begin
          instr = {joff[20], joff[10:1], joff[11], joff[19:12], bits[0] ? 5'd1 : 5'd0,
                   7'b1101111};
        end
        6: begin
          instr = bits[0] ? 32'h0000_8067 :
                  {bits[31:20], bits[19:15], 3'b000, bits[1] ? 5'd1 : bits[11:7], 7'b1100111};
        end
        7, 8, 9, 10, 11, 12, 13: begin
          instr = {16'h0000, bits[15:2], (bits[1:0] == 2'b11) ? 2'b00 : bits[1:0]};
        end
        default: instr = {bits[31:2], 2'b11};
      endcase
      prog[i] = instr[15:0];
      if (instr[1:0] == 2'b11) begin
        if (i + 1 < MEM_HALFWORDS) begin
          prog[i + 1] = instr[31:16];
        end
        i = i + 2;
      end else begin
        i = i + 1;
      end
    end
  endtask

  task automatic drive_random_inputs();
    int pick;
    load_valid = 1'b0;
    stall = ($urandom % 5 == 0);
    // picks 4 and 5 raise two strobes at once to exercise the priority
    pick = $urandom % 100;
    trap = (pick == 0 || pick == 4);
    mret = (pick == 1 || pick == 5);
    redirect = (pick >= 2 && pick <= 5);
    epc = ADDR_WIDTH'($urandom) & EVEN_MASK;
    redirect_pc = ADDR_WIDTH'($urandom) & EVEN_MASK;
    resolve_valid = ($urandom % 3 == 0);
    resolve_pc = ($urandom % 2 == 0) ? exp_pc : ADDR_WIDTH'($urandom) & EVEN_MASK;
    resolve_taken = ($urandom % 3 != 0);
    if (trap || mret || redirect) begin
      redirects_seen++;
    end
  endtask

  task automatic check_outputs();
    assert (fetch_unit_inst.pc === exp_pc)
      else report_mismatch("pc", exp_pc, fetch_unit_inst.pc);
    assert (fetch_valid === exp_valid)
      else report_mismatch("fetch_valid", exp_valid, fetch_valid);
    assert (fetch_taken === exp_taken)
      else report_mismatch("fetch_taken", exp_taken, fetch_taken);
    assert (fetch_instr === exp_instr)
      else report_mismatch("fetch_instr", exp_instr, fetch_instr);
    if (exp_valid) begin
      assert (fetch_pc === exp_fetch_pc)
        else report_mismatch("fetch_pc", exp_fetch_pc, fetch_pc);
      assert (fetch_len4 === exp_len4)
        else report_mismatch("fetch_len4", exp_len4, fetch_len4);
    end
  endtask

  initial begin
    int i;
    int cycle;
    void'($urandom(31141));
    reset = 1'b0;
    stall = 1'b1;
    load_valid = 1'b0;
    load_addr = '0;
    load_data = '0;
    trap = 1'b0;
    mret = 1'b0;
    epc = '0;
    redirect = 1'b0;
    redirect_pc = '0;
    resolve_valid = 1'b0;
    resolve_pc = '0;
    resolve_taken = 1'b0;
    results_seen = 0;
    taken_seen = 0;
    redirects_seen = 0;
    build_program();
    reset_model();
    // the buffer fills under reset and then while stall keeps the front end idle
    for (i = 0; i < MEM_HALFWORDS; i++) begin
      @(negedge clock);
      if (i == RESET_CYCLES - 1) begin
        reset = 1'b1;
      end
      load_valid = 1'b1;
      load_addr = LOAD_BITS'(i);
      load_data = prog[i];
      exp_mem[i] = prog[i];
    end
    for (cycle = 0; cycle < RUN_CYCLES; cycle++) begin
      @(negedge clock);
      check_outputs();
      if (new_result) begin
        results_seen++;
        if (exp_taken) begin
          taken_seen++;
        end
      end
      drive_random_inputs();
      step_model();
    end
    @(negedge clock);
    check_outputs();
    if (new_result) begin
      results_seen++;
    end
    $display("%0d results checked, %0d predicted taken, %0d redirect cycles",
             results_seen, taken_seen, redirects_seen);
    assert (results_seen > RUN_CYCLES / 4)
      else abort_run("too few valid fetch results were produced");
    assert (taken_seen > 0)
      else abort_run("no fetch result was predicted taken");
    $display("sim passed");
    $finish;
  end

  initial begin
    cycle_count = 0;
    forever begin
      @(posedge clock);
      cycle_count++;
      if (cycle_count > TIMEOUT_CYCLES) begin
        abort_run("timeout, the run did not finish within the cycle limit");
      end
    end
  end

endmodule
